// File: compile.f
verilog/icache_pkg.sv
verilog/dual_port_ram.sv
verilog/plru.sv
verilog/icache.sv
verilog/uncached_reader.sv
verilog/axi_read_arbiter.sv
verilog/fetch_mem_top.sv
tests/axi_read_mem.sv
tests/fetch_mem_assertions.sv
tests/tb_fetch_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fetch memory testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -j 0 --top-module tb_fetch_mem \
	-f compile.f -o sim_fetch_mem > build.log 2>&1 \
	&& ./obj_dir/sim_fetch_mem > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"

grep -q "Simulation completed successfully" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

// File: tests/tb_fetch_mem.sv
`timescale 1ns/1ps

module tb_fetch_mem;

	localparam int wait_limit = 3000;

	logic        clk;
	logic        rst;
	logic        read;
	logic [31:0] addr;
	logic        stall;
	logic        ready;
	logic        valid;
	logic [63:0] rdata;
	logic        ucr_req;
	logic [31:0] ucr_addr;
	logic        ucr_busy;
	logic        ucr_valid;
	logic [31:0] ucr_rdata;
	logic        inv;
	logic [31:0] inv_addr;
	logic        m_arvalid;
	logic [31:0] m_araddr;
	logic [7:0]  m_arlen;
	logic [2:0]  m_arsize;
	logic        m_arready;
	logic        m_rvalid;
	logic [31:0] m_rdata;
	logic        m_rlast;
	logic        m_rready;

	int          error_count;
	int          test_count;
	int          ar_count;
	int          overlap_count;
	logic [31:0] last_araddr;
	logic [7:0]  last_arlen;
	logic [2:0]  last_arsize;
	logic        burst_open;
	int unsigned seed_val;

	fetch_mem_top u_dut (.*);

	axi_read_mem u_mem (
		.clk     (clk),
		.rst     (rst),
		.arvalid (m_arvalid),
		.araddr  (m_araddr),
		.arlen   (m_arlen),
		.arready (m_arready),
		.rvalid  (m_rvalid),
		.rdata   (m_rdata),
		.rlast   (m_rlast),
		.rready  (m_rready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// external channel monitor
	always @(posedge clk) begin
		if (rst) begin
			ar_count <= 0;
			overlap_count <= 0;
			burst_open <= 1'b0;
		end else begin
			// a second request has to wait for the open burst to end
			if (m_arvalid && burst_open) begin
				overlap_count <= overlap_count + 1;
			end
			if (m_arvalid && m_arready) begin
				ar_count <= ar_count + 1;
				last_araddr <= m_araddr;
				last_arlen <= m_arlen;
				last_arsize <= m_arsize;
				burst_open <= 1'b1;
			end else if (m_rvalid && m_rready && m_rlast) begin
				burst_open <= 1'b0;
			end
		end
	end

	function automatic logic [31:0] mem_word(input logic [31:0] a);
		return {a[31:2], 2'b00} ^ 32'h5a5a0000;
	endfunction

	// upper half from the next word
	function automatic logic [63:0] fetch_word(input logic [31:0] a);
		logic [31:0] base;
		base = {a[31:3], 3'b000};
		return {mem_word(base + 32'd4), mem_word(base)};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
		error_count++;
	endtask

	task automatic report_problem(input string msg);
		$display("%0t %s", $time, msg);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int err_start);
		test_count++;
		$display("test %s finished with %0d errors", name, error_count - err_start);
	endtask

	// one fetch, optionally with an uncached read issued in the acceptance cycle
	task automatic fetch(input logic [31:0] a, input bit with_ucr, input logic [31:0] ua,
			output int lat);
		int n;
		bit got_fetch;
		bit got_ucr;
		lat = -1;
		read <= 1'b1;
		addr <= a;
		if (with_ucr) begin
			ucr_req <= 1'b1;
			ucr_addr <= ua;
		end
		n = 0;
		do begin
			@(posedge clk);
			ucr_req <= 1'b0;
			n++;
		end while (stall && n < wait_limit);
		read <= 1'b0;
		if (stall) begin
			report_problem("timeout: the cache never accepted the read");
			return;
		end
		got_fetch = 1'b0;
		got_ucr = !with_ucr;
		n = 0;
		while (!(got_fetch && got_ucr) && n < wait_limit) begin
			@(posedge clk);
			n++;
			if (valid) begin
				if (got_fetch) begin
					report_problem("valid pulsed twice for one read");
				end
				got_fetch = 1'b1;
				lat = n;
				if (rdata !== fetch_word(a)) begin
					report_mismatch("rdata", rdata, fetch_word(a));
				end
			end
			if (ucr_valid) begin
				got_ucr = 1'b1;
				if (ucr_busy !== 1'b0) begin
					report_mismatch("ucr_busy", 64'(ucr_busy), 64'd0);
				end
				if (ucr_rdata !== mem_word(ua)) begin
					report_mismatch("ucr_rdata", 64'(ucr_rdata), 64'(mem_word(ua)));
				end
			end else if (!got_ucr && !ucr_busy) begin
				report_problem("ucr_busy was low before ucr_valid");
			end
		end
		if (!got_fetch) begin
			report_problem("timeout: no valid from the cache");
		end
		if (!got_ucr) begin
			report_problem("timeout: no ucr_valid from the uncached reader");
		end
	endtask

	task automatic fetch_check(input logic [31:0] a, input bit expect_miss);
		int ar_start;
		int lat;
		ar_start = ar_count;
		fetch(a, 1'b0, 32'd0, lat);
		if (expect_miss) begin
			if (ar_count != ar_start + 1) begin
				report_mismatch("ar handshakes", 64'(ar_count), 64'(ar_start + 1));
			end
		end else begin
			if (ar_count != ar_start) begin
				report_mismatch("ar handshakes", 64'(ar_count), 64'(ar_start));
			end
			if (lat != 2) begin
				report_mismatch("valid latency", 64'(lat), 64'd2);
			end
		end
	endtask

	task automatic test_reset();
		int err_start;
		int n;
		bit saw_low;
		err_start = error_count;
		for (n = 0; n < 16; n++) begin
			@(posedge clk);
			if (n > 0 && (valid || ucr_valid || m_arvalid || m_rready)) begin
				report_problem("an output was active during reset");
			end
		end
		rst <= 1'b0;
		saw_low = 1'b0;
		n = 0;
		while (n < wait_limit) begin
			@(posedge clk);
			n++;
			if (valid || ucr_valid || m_arvalid || m_rready) begin
				report_problem("an output was active during the sweep");
			end
			if (ready) begin
				break;
			end
			saw_low = 1'b1;
			if (!stall) begin
				report_problem("stall was low while ready was low");
			end
		end
		if (!ready) begin
			report_problem("timeout: ready never rose after reset");
		end else if (stall) begin
			report_mismatch("stall", 64'(stall), 64'd0);
		end
		if (!saw_low) begin
			report_problem("ready was never low after reset");
		end
		finish_test("reset", err_start);
	endtask

	task automatic test_miss_hit();
		int err_start;
		err_start = error_count;
		fetch_check(32'h0000_1008, 1'b1);
		if (last_araddr !== 32'h0000_1000) begin
			report_mismatch("m_araddr", 64'(last_araddr), 64'h1000);
		end
		if (last_arlen !== 8'd7) begin
			report_mismatch("m_arlen", 64'(last_arlen), 64'd7);
		end
		if (last_arsize !== 3'd2) begin
			report_mismatch("m_arsize", 64'(last_arsize), 64'd2);
		end
		fetch_check(32'h0000_1018, 1'b0);
		finish_test("miss_hit", err_start);
	endtask

	task automatic test_replacement();
		int err_start;
		int k;
		logic [31:0] lines [5];
		err_start = error_count;
		// five tags at set 5
		for (k = 0; k < 5; k++) begin
			lines[k] = (32'(k + 1) << 9) | (32'd5 << 5) | 32'h8;
		end
		for (k = 0; k < 5; k++) begin
			fetch_check(lines[k], 1'b1);
		end
		for (k = 1; k < 4; k++) begin
			fetch_check(lines[k], 1'b0);
		end
		fetch_check(lines[0], 1'b1);
		finish_test("replacement", err_start);
	endtask

	task automatic test_invalidation();
		int err_start;
		err_start = error_count;
		fetch_check(32'h0000_1008, 1'b0);
		inv <= 1'b1;
		inv_addr <= 32'h0000_1008;
		@(posedge clk);
		inv <= 1'b0;
		repeat (2) @(posedge clk);
		fetch_check(32'h0000_1008, 1'b1);
		finish_test("invalidation", err_start);
	endtask

	task automatic test_sharing();
		int err_start;
		int ar_start;
		int ovl_start;
		int lat;
		err_start = error_count;
		ar_start = ar_count;
		ovl_start = overlap_count;
		fetch(32'h0000_3450, 1'b1, 32'h0000_0a16, lat);
		if (ar_count != ar_start + 2) begin
			report_mismatch("ar handshakes", 64'(ar_count), 64'(ar_start + 2));
		end
		if (overlap_count != ovl_start) begin
			report_problem("m_arvalid was high inside an open burst");
		end
		finish_test("sharing", err_start);
	endtask

	task automatic test_random();
		int err_start;
		int ovl_start;
		int i;
		int lat;
		logic [31:0] a;
		logic [31:0] ua;
		bit use_ucr;
		err_start = error_count;
		ovl_start = overlap_count;
		for (i = 0; i < 40; i++) begin
			a = 32'h0001_0000 + ($urandom % 32'd4096);
			ua = 32'h0001_0000 + ($urandom % 32'd4096);
			use_ucr = ($urandom % 2) == 1;
			fetch(a, use_ucr, ua, lat);
		end
		if (overlap_count != ovl_start) begin
			report_problem("m_arvalid was high inside an open burst");
		end
		finish_test("random", err_start);
	endtask

	initial begin
		rst = 1'b1;
		read = 1'b0;
		addr = '0;
		ucr_req = 1'b0;
		ucr_addr = '0;
		inv = 1'b0;
		inv_addr = '0;
		error_count = 0;
		test_count = 0;
		seed_val = $urandom(32'hd9206c32);
		test_reset();
		test_miss_hit();
		test_replacement();
		test_invalidation();
		test_sharing();
		test_random();
		$display("tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: tests/fetch_mem_assertions.sv
`timescale 1ns/1ps

module fetch_mem_assertions (
	input logic        clk,
	input logic        rst,
	input logic        m_arvalid,
	input logic [31:0] m_araddr,
	input logic [7:0]  m_arlen,
	input logic        m_arready,
	input logic        m_rvalid,
	input logic        m_rlast,
	input logic        m_rready
);

	logic       burst_open;
	logic [7:0] beat_cnt;
	logic [7:0] burst_len_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			burst_open <= 1'b0;
			beat_cnt <= '0;
			burst_len_q <= '0;
		end else if (m_arvalid && m_arready) begin
			burst_open <= 1'b1;
			beat_cnt <= '0;
			burst_len_q <= m_arlen;
		end else if (m_rvalid && m_rready) begin
			beat_cnt <= beat_cnt + 8'd1;
			if (m_rlast) begin
				burst_open <= 1'b0;
			end
		end
	end

	ar_stable: assert property (@(posedge clk) disable iff (rst)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
		else $error("arvalid or araddr changed before arready");

	rready_in_burst: assert property (@(posedge clk) disable iff (rst)
		$rose(m_rready) |-> burst_open)
		else $error("rready rose with no open burst");

	// rlast exactly on beat arlen
	beat_count: assert property (@(posedge clk) disable iff (rst)
		m_rvalid && m_rready |-> burst_open && (m_rlast == (beat_cnt == burst_len_q)))
		else $error("burst beat count differs from arlen plus one");

endmodule

bind axi_read_arbiter fetch_mem_assertions u_assert (
	.clk       (clk),
	.rst       (rst),
	.m_arvalid (m_arvalid),
	.m_araddr  (m_araddr),
	.m_arlen   (m_arlen),
	.m_arready (m_arready),
	.m_rvalid  (m_rvalid),
	.m_rlast   (m_rlast),
	.m_rready  (m_rready)
);

// File: tests/axi_read_mem.sv
`timescale 1ns/1ps

module axi_read_mem (
	input  logic        clk,
	input  logic        rst,
	input  logic        arvalid,
	input  logic [31:0] araddr,
	input  logic [7:0]  arlen,
	output logic        arready,
	output logic        rvalid,
	output logic [31:0] rdata,
	output logic        rlast,
	input  logic        rready
);

	logic        busy;
	logic [31:0] beat_addr;
	logic [7:0]  beats_left;

	// one burst at a time, random arready delay and gaps between beats
	always_ff @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rdata <= '0;
			busy <= 1'b0;
			beat_addr <= '0;
			beats_left <= '0;
		end else if (!busy) begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				busy <= 1'b1;
				beat_addr <= {araddr[31:2], 2'b00};
				beats_left <= arlen;
			end else begin
				arready <= arvalid && (($urandom % 3) == 0);
			end
		end else if (rvalid) begin
			if (rready) begin
				rvalid <= 1'b0;
				rlast <= 1'b0;
				beat_addr <= beat_addr + 32'd4;
				beats_left <= beats_left - 8'd1;
				if (rlast) begin
					busy <= 1'b0;
				end
			end
		end else if (($urandom % 2) == 0) begin
			rvalid <= 1'b1;
			// content rule of the model
			rdata <= beat_addr ^ 32'h5a5a0000;
			rlast <= beats_left == 8'd0;
		end
	end

endmodule

// File: verilog/fetch_mem_top.sv
`timescale 1ns/1ps

module fetch_mem_top (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             read,
	input  logic [31:0]                      addr,
	output logic                             stall,
	output logic                             ready,
	output logic                             valid,
	output logic [icache_pkg::word_bits-1:0] rdata,
	input  logic                             ucr_req,
	input  logic [31:0]                      ucr_addr,
	output logic                             ucr_busy,
	output logic                             ucr_valid,
	output logic [31:0]                      ucr_rdata,
	input  logic                             inv,
	input  logic [31:0]                      inv_addr,
	output logic                             m_arvalid,
	output logic [31:0]                      m_araddr,
	output logic [7:0]                       m_arlen,
	output logic [2:0]                       m_arsize,
	input  logic                             m_arready,
	input  logic                             m_rvalid,
	input  logic [31:0]                      m_rdata,
	input  logic                             m_rlast,
	output logic                             m_rready
);

	// cache side of the arbiter
	logic        ic_arvalid;
	logic [31:0] ic_araddr;
	logic [7:0]  ic_arlen;
	logic [2:0]  ic_arsize;
	logic        ic_arready;
	logic        ic_rvalid;
	logic [31:0] ic_rdata;
	logic        ic_rlast;
	logic        ic_rready;

	// uncached side
	logic        uc_arvalid;
	logic [31:0] uc_araddr;
	logic [7:0]  uc_arlen;
	logic [2:0]  uc_arsize;
	logic        uc_arready;
	logic        uc_rvalid;
	logic [31:0] uc_rdata;
	logic        uc_rlast;
	logic        uc_rready;

	icache u_icache (.*);

	uncached_reader u_ucr (.*);

	axi_read_arbiter u_arb (.*);

endmodule

// File: verilog/axi_read_arbiter.sv
`timescale 1ns/1ps

module axi_read_arbiter (
	input  logic        clk,
	input  logic        rst,
	input  logic        ic_arvalid,
	input  logic [31:0] ic_araddr,
	input  logic [7:0]  ic_arlen,
	input  logic [2:0]  ic_arsize,
	output logic        ic_arready,
	output logic        ic_rvalid,
	output logic [31:0] ic_rdata,
	output logic        ic_rlast,
	input  logic        ic_rready,
	input  logic        uc_arvalid,
	input  logic [31:0] uc_araddr,
	input  logic [7:0]  uc_arlen,
	input  logic [2:0]  uc_arsize,
	output logic        uc_arready,
	output logic        uc_rvalid,
	output logic [31:0] uc_rdata,
	output logic        uc_rlast,
	input  logic        uc_rready,
	output logic        m_arvalid,
	output logic [31:0] m_araddr,
	output logic [7:0]  m_arlen,
	output logic [2:0]  m_arsize,
	input  logic        m_arready,
	input  logic        m_rvalid,
	input  logic [31:0] m_rdata,
	input  logic        m_rlast,
	output logic        m_rready
);

	// owner and last_grant: 1 means the uncached reader
	logic busy;
	logic owner;
	logic last_grant;
	logic addr_done;
	logic grant_uc;

	// on a tie the side not granted last time wins
	assign grant_uc = uc_arvalid && (!ic_arvalid || !last_grant);

	assign m_arvalid = busy && !addr_done && (owner ? uc_arvalid : ic_arvalid);
	assign m_araddr = owner ? uc_araddr : ic_araddr;
	assign m_arlen = owner ? uc_arlen : ic_arlen;
	assign m_arsize = owner ? uc_arsize : ic_arsize;
	assign m_rready = busy && addr_done && (owner ? uc_rready : ic_rready);

	assign ic_arready = busy && !addr_done && !owner && m_arready;
	assign uc_arready = busy && !addr_done && owner && m_arready;
	assign ic_rvalid = busy && addr_done && !owner && m_rvalid;
	assign uc_rvalid = busy && addr_done && owner && m_rvalid;
	assign ic_rdata = owner ? '0 : m_rdata;
	assign uc_rdata = owner ? m_rdata : '0;
	assign ic_rlast = !owner && m_rlast;
	assign uc_rlast = owner && m_rlast;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			owner <= 1'b0;
			last_grant <= 1'b1;
			addr_done <= 1'b0;
		end else if (!busy) begin
			if (ic_arvalid || uc_arvalid) begin
				busy <= 1'b1;
				owner <= grant_uc;
				last_grant <= grant_uc;
				addr_done <= 1'b0;
			end
		end else if (!addr_done) begin
			if (m_arvalid && m_arready) begin
				addr_done <= 1'b1;
			end
		end else if (m_rvalid && m_rready && m_rlast) begin
			// burst done, channel free
			busy <= 1'b0;
			addr_done <= 1'b0;
		end
	end

endmodule

// File: verilog/uncached_reader.sv
`timescale 1ns/1ps

module uncached_reader (
	input  logic        clk,
	input  logic        rst,
	input  logic        ucr_req,
	input  logic [31:0] ucr_addr,
	output logic        ucr_busy,
	output logic        ucr_valid,
	output logic [31:0] ucr_rdata,
	output logic        uc_arvalid,
	output logic [31:0] uc_araddr,
	output logic [7:0]  uc_arlen,
	output logic [2:0]  uc_arsize,
	input  logic        uc_arready,
	input  logic        uc_rvalid,
	input  logic [31:0] uc_rdata,
	input  logic        uc_rlast,
	output logic        uc_rready
);

	import icache_pkg::*;

	logic [1:0]  state;
	logic [31:0] addr_q;

	assign ucr_busy = state != ucr_idle;
	assign uc_arvalid = state == ucr_ar;
	assign uc_araddr = addr_q;
	// single beat
	assign uc_arlen = '0;
	assign uc_arsize = beat_size;
	assign uc_rready = state == ucr_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ucr_idle;
			ucr_valid <= 1'b0;
		end else begin
			ucr_valid <= 1'b0;
			case (state)
				ucr_idle: if (ucr_req) state <= ucr_ar;
				ucr_ar: if (uc_arready) state <= ucr_r;
				ucr_r: begin
					if (uc_rvalid && uc_rlast) begin
						ucr_valid <= 1'b1;
						state <= ucr_idle;
					end
				end
				default: state <= ucr_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == ucr_idle) && ucr_req) begin
			addr_q <= {ucr_addr[31:2], 2'b00};
		end
		if ((state == ucr_r) && uc_rvalid) begin
			ucr_rdata <= uc_rdata;
		end
	end

endmodule

// File: verilog/icache.sv
`timescale 1ns/1ps

module icache (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            inv,
	input  logic [31:0]                     inv_addr,
	input  logic                            read,
	input  logic [31:0]                     addr,
	output logic                            stall,
	output logic                            ready,
	output logic                            valid,
	output logic [icache_pkg::word_bits-1:0] rdata,
	output logic                            ic_arvalid,
	output logic [31:0]                     ic_araddr,
	output logic [7:0]                      ic_arlen,
	output logic [2:0]                      ic_arsize,
	input  logic                            ic_arready,
	input  logic                            ic_rvalid,
	input  logic [31:0]                     ic_rdata,
	input  logic                            ic_rlast,
	output logic                            ic_rready
);

	import icache_pkg::*;

	logic [2:0]            state;
	logic [index_bits-1:0] sweep_cnt;
	logic [2:0]            beat_cnt;

	fetch_addr_u req_addr;
	fetch_addr_u inv_fa;
	fetch_addr_u s2_addr;
	logic        s2_read;

	logic                  pipe_inv;
	logic [index_bits-1:0] pipe_inv_index;

	tag_entry_t [way_num-1:0] tag_rdata;
	line_t [way_num-1:0]      line_rdata;
	tag_entry_t               tag_wdata;
	line_t                    line_wdata;
	logic [way_num-1:0]       tag_we;
	logic [way_num-1:0]       line_we;
	logic [index_bits-1:0]    ram_waddr;
	logic [index_bits-1:0]    ram_raddr;

	logic [way_num-1:0]          hit;
	logic                        s2_hit;
	logic [1:0]                  hit_way;
	logic [word_bits-1:0]        hit_word;
	logic [1:0]                  fill_way;
	logic [1:0]                  fill_way_n;
	logic [set_num-1:0][1:0]     victim;
	logic [line_bits/32-1:0][31:0] line_buf;

	assign req_addr.raw = addr;
	assign inv_fa.raw = inv_addr;

	// stage two: tag compare and word select
	always_comb begin
		hit_word = '0;
		hit_way = '0;
		for (int i = 0; i < way_num; i++) begin
			hit[i] = tag_rdata[i].valid && (tag_rdata[i].tag == s2_addr.f.tag);
			if (hit[i]) begin
				hit_word = line_rdata[i][s2_addr.f.word_sel];
				hit_way = 2'(i);
			end
		end
	end

	assign s2_hit = |hit;

	// lowest invalid way, else the plru victim
	always_comb begin
		fill_way_n = victim[s2_addr.f.index];
		for (int i = way_num - 1; i >= 0; i--) begin
			if (!tag_rdata[i].valid) begin
				fill_way_n = 2'(i);
			end
		end
	end

	assign ready = state != st_sweep;
	assign stall = (state == st_sweep) || (s2_read && ((state != st_idle) || !s2_hit));

	// hold the missed set on the read port until the refill is seen
	assign ram_raddr = stall ? s2_addr.f.index : req_addr.f.index;
	assign line_wdata = line_buf;

	always_comb begin
		tag_we = '0;
		line_we = '0;
		ram_waddr = s2_addr.f.index;
		tag_wdata.valid = 1'b0;
		tag_wdata.tag = s2_addr.f.tag;
		if (pipe_inv) begin
			tag_we = '1;
			ram_waddr = pipe_inv_index;
		end else if (state == st_sweep) begin
			tag_we = '1;
			ram_waddr = sweep_cnt;
		end else if (state == st_write) begin
			tag_we[fill_way] = 1'b1;
			line_we[fill_way] = 1'b1;
			tag_wdata.valid = 1'b1;
		end
	end

	assign ic_arvalid = state == st_ar;
	assign ic_araddr = {s2_addr.f.tag, s2_addr.f.index, {line_off_bits{1'b0}}};
	assign ic_arlen = burst_len;
	assign ic_arsize = beat_size;
	assign ic_rready = state == st_recv;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_sweep;
			sweep_cnt <= '0;
			beat_cnt <= '0;
		end else begin
			case (state)
				st_sweep: begin
					// an inv write takes the port, so the sweep waits
					if (!pipe_inv) begin
						sweep_cnt <= sweep_cnt + 1'b1;
						if (&sweep_cnt) begin
							state <= st_idle;
						end
					end
				end
				st_idle: begin
					if (s2_read && !s2_hit) begin
						state <= st_ar;
					end
				end
				st_ar: begin
					beat_cnt <= '0;
					if (ic_arready) begin
						state <= st_recv;
					end
				end
				st_recv: begin
					if (ic_rvalid) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (ic_rlast) begin
							state <= st_write;
						end
					end
				end
				st_write: begin
					if (!pipe_inv) begin
						state <= st_reread;
					end
				end
				st_reread: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s2_read <= 1'b0;
			valid <= 1'b0;
			pipe_inv <= 1'b0;
		end else begin
			if (!stall) begin
				s2_read <= read;
			end
			valid <= (state == st_idle) && s2_read && s2_hit;
			pipe_inv <= inv;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			s2_addr <= req_addr;
		end
		pipe_inv_index <= inv_fa.f.index;
		rdata <= hit_word;
		if (state == st_idle) begin
			fill_way <= fill_way_n;
		end
		// beat 0 lands in the low bits
		if ((state == st_recv) && ic_rvalid) begin
			line_buf[beat_cnt] <= ic_rdata;
		end
	end

	for (genvar w = 0; w < way_num; w++) begin : gen_way
		dual_port_ram #(
			.data_t (tag_entry_t),
			.depth  (set_num)
		) u_tag_ram (
			.clk   (clk),
			.rst   (rst),
			.we    (tag_we[w]),
			.waddr (ram_waddr),
			.wdata (tag_wdata),
			.raddr (ram_raddr),
			.rdata (tag_rdata[w])
		);

		dual_port_ram #(
			.data_t (line_t),
			.depth  (set_num)
		) u_line_ram (
			.clk   (clk),
			.rst   (rst),
			.we    (line_we[w]),
			.waddr (ram_waddr),
			.wdata (line_wdata),
			.raddr (ram_raddr),
			.rdata (line_rdata[w])
		);
	end

	for (genvar g = 0; g < set_num; g++) begin : gen_plru
		plru u_plru (
			.clk     (clk),
			.rst     (rst),
			.update  ((state == st_idle) && s2_read && s2_hit &&
				(s2_addr.f.index == index_bits'(g))),
			.hit_way (hit_way),
			.victim  (victim[g])
		);
	end

endmodule

// File: verilog/plru.sv
`timescale 1ns/1ps

module plru (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   update,
	input  logic [$clog2(icache_pkg::way_num)-1:0] hit_way,
	output logic [$clog2(icache_pkg::way_num)-1:0] victim
);

	// tree[0] picks the pair, tree[1] ways 0/1, tree[2] ways 2/3
	logic [2:0] tree;

	assign victim = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

	always_ff @(posedge clk) begin
		if (rst) begin
			tree <= '0;
		end else if (update) begin
			// point away from the way just used
			tree[0] <= !hit_way[1];
			if (hit_way[1]) begin
				tree[2] <= !hit_way[0];
			end else begin
				tree[1] <= !hit_way[0];
			end
		end
	end

endmodule

// File: verilog/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
	parameter type data_t = logic [31:0],
	parameter int  depth  = icache_pkg::set_num
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     we,
	input  logic [$clog2(depth)-1:0] waddr,
	input  data_t                    wdata,
	input  logic [$clog2(depth)-1:0] raddr,
	output data_t                    rdata
);

	data_t mem [depth];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read, old value on a same-address write
	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= '0;
		end else begin
			rdata <= mem[raddr];
		end
	end

endmodule

// File: verilog/icache_pkg.sv
package icache_pkg;

	// cache geometry
	localparam int line_bits     = 256;
	localparam int word_bits     = 64;
	localparam int way_num       = 4;
	localparam int set_num       = 16;
	localparam int index_bits    = 4;
	localparam int line_off_bits = 5;
	localparam int word_sel_bits = 2;
	localparam int tag_bits      = 23;

	// refill burst, 8 beats of 4 bytes
	localparam logic [7:0] burst_len = 8'd7;
	localparam logic [2:0] beat_size = 3'd2;

	// icache refill FSM
	localparam logic [2:0] st_sweep  = 3'd0;
	localparam logic [2:0] st_idle   = 3'd1;
	localparam logic [2:0] st_ar     = 3'd2;
	localparam logic [2:0] st_recv   = 3'd3;
	localparam logic [2:0] st_write  = 3'd4;
	localparam logic [2:0] st_reread = 3'd5;

	// uncached reader FSM
	localparam logic [1:0] ucr_idle = 2'd0;
	localparam logic [1:0] ucr_ar   = 2'd1;
	localparam logic [1:0] ucr_r    = 2'd2;

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [tag_bits-1:0]      tag;
			logic [index_bits-1:0]    index;
			logic [word_sel_bits-1:0] word_sel;
			logic [2:0]               byte_off;
		} f;
	} fetch_addr_u;

	typedef struct packed {
		logic                valid;
		logic [tag_bits-1:0] tag;
	} tag_entry_t;

	typedef logic [line_bits/word_bits-1:0][word_bits-1:0] line_t;

endpackage
